/* common/uart_defines.svh */
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

`define UART_FIFO_DEPTH 16
`define UART_CNT_W      5
`define UART_OVERSAMPLE 16
`define UART_ADDR_W     3

`define UART_REG_DATA   3'd0
`define UART_REG_DLM    3'd1
`define UART_REG_LCR    3'd3
`define UART_REG_LSR    3'd5

`endif

/* common/uart_pkg.sv */
`default_nettype none

package uart_pkg;

	// line control byte, top bit first.
	typedef struct packed {
		logic       dlab;
		logic [1:0] rsvd;
		logic       even_par;
		logic       par_en;
		logic       stop2;     // two stop bits when set.
		logic [1:0] wlen;      // word length minus 5.
	} lcr_t;

	// one received character with its error flags.
	typedef struct packed {
		logic [7:0] data;
		logic       par_err;
		logic       frm_err;
	} rx_entry_t;

endpackage

`default_nettype wire

/* filelist.f */
+incdir+common
common/uart_pkg.sv
source/uart_fifo.sv
source/uart_baud_gen.sv
source/uart_regs.sv
transmitter/uart_tx.sv
receiver/uart_rx.sv
source/uart_top.sv
verification/uart_tb.sv

/* receiver/uart_rx.sv */
`timescale 1ns/1ns
`default_nettype none
`include "uart_defines.svh"

module uart_rx
	import uart_pkg::*;
(
	input  wire        clk,
	input  wire        wb_rst_i,
	input  wire        tick_i,
	input  wire lcr_t  lcr_i,
	input  wire        srx_pad_i,
	input  wire        pop_i,
	output rx_entry_t  rx_head_o,
	output logic       rx_ready_o,
	output logic       rx_overrun_o
);
	localparam int TW = $clog2(`UART_OVERSAMPLE);
	localparam logic [TW-1:0] TICK_LAST = TW'(`UART_OVERSAMPLE - 1);
	localparam logic [TW-1:0] TICK_MID  = TW'(`UART_OVERSAMPLE / 2 - 1);

	typedef enum logic [2:0] {
		R_IDLE, R_START, R_DATA, R_PARITY, R_STOP, R_PUSH, R_WAIT_HIGH
	} rx_state_t;

	rx_state_t     state;
	logic [1:0]    sync;
	logic          rx_s;
	logic          rx_prev;
	logic [TW-1:0] tick_cnt;
	logic [2:0]    bit_cnt;
	rx_entry_t     entry;
	logic          smp;
	logic          push_req;
	logic          full;
	logic          empty;

	uart_fifo #(.WIDTH($bits(rx_entry_t))) i_rx_fifo (
		.clk      (clk),
		.wb_rst_i (wb_rst_i),
		.push_i   (push_req),
		.pop_i    (pop_i),
		.data_i   (entry),
		.data_o   (rx_head_o),
		.count_o  (),
		.full_o   (full),
		.empty_o  (empty)
	);

	assign rx_s         = sync[1];
	assign smp          = tick_i && tick_cnt == TICK_LAST;    // middle of the next bit.
	assign push_req     = tick_i && state == R_PUSH && tick_cnt == TW'(1);
	assign rx_ready_o   = ~empty;
	assign rx_overrun_o = push_req & full & ~pop_i;

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			sync    <= 2'b11;
			rx_prev <= 1'b1;
		end
		else
		begin
			sync    <= {sync[0], srx_pad_i};
			rx_prev <= rx_s;
		end
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			state    <= R_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			entry    <= '0;
		end
		else
		begin
			if (tick_i)
				tick_cnt <= (tick_cnt == TICK_LAST) ? '0 : tick_cnt + 1'b1;
			case (state)
				R_IDLE:
				begin
					if (rx_prev && !rx_s)
					begin
						state    <= R_START;
						tick_cnt <= '0;
					end
				end
				R_START:
				begin
					if (tick_i && tick_cnt == TICK_MID)
					begin
						if (rx_s)
							state <= R_IDLE;          // glitch, not a start bit.
						else
						begin
							state    <= R_DATA;
							tick_cnt <= '0;
							bit_cnt  <= '0;
							entry    <= '0;
						end
					end
				end
				R_DATA:
				begin
					if (smp)
					begin
						entry.data[bit_cnt] <= rx_s;
						if (bit_cnt == {1'b1, lcr_i.wlen})
							state <= lcr_i.par_en ? R_PARITY : R_STOP;
						else
							bit_cnt <= bit_cnt + 1'b1;
					end
				end
				R_PARITY:
				begin
					if (smp)
					begin
						entry.par_err <= ^{entry.data, rx_s} ^ ~lcr_i.even_par;
						state         <= R_STOP;
					end
				end
				R_STOP:
				begin
					if (smp)
					begin
						entry.frm_err <= ~rx_s;     // only the first stop bit.
						state         <= R_PUSH;
					end
				end
				R_PUSH:
				begin
					if (push_req)
						state <= entry.frm_err ? R_WAIT_HIGH : R_IDLE;
				end
				R_WAIT_HIGH:
				begin
					if (rx_s)
						state <= R_IDLE;
				end
				default: state <= R_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the UART testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module uart_tb -f filelist.f -o uart_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/uart_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Simulation finished: PASS"; then
	exit 0
fi
exit 1

/* source/uart_baud_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_baud_gen (
	input  wire        clk,
	input  wire        wb_rst_i,
	input  wire [15:0] divisor_i,
	input  wire        div_load_i,
	output logic       tick_o
);
	logic [15:0] cnt;

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			cnt    <= '0;
			tick_o <= 1'b0;
		end
		else if (div_load_i || divisor_i == '0)
		begin
			cnt    <= divisor_i;
			tick_o <= 1'b0;                // silent while divisor is zero.
		end
		else if (cnt <= 16'd1)
		begin
			cnt    <= divisor_i;
			tick_o <= 1'b1;
		end
		else
		begin
			cnt    <= cnt - 1'b1;
			tick_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* source/uart_fifo.sv */
`timescale 1ns/1ns
`default_nettype none
`include "uart_defines.svh"

module uart_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = `UART_FIFO_DEPTH
) (
	input  wire                   clk,
	input  wire                   wb_rst_i,
	input  wire                   push_i,
	input  wire                   pop_i,
	input  wire [WIDTH-1:0]       data_i,
	output logic [WIDTH-1:0]      data_o,
	output logic [`UART_CNT_W-1:0] count_o,
	output logic                  full_o,
	output logic                  empty_o
);
	localparam int PW = $clog2(DEPTH);
	localparam int CW = `UART_CNT_W;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PW-1:0]    wr_ptr;
	logic [PW-1:0]    rd_ptr;
	logic             do_push;
	logic             do_pop;

	assign empty_o = (count_o == '0);
	assign full_o  = (count_o == CW'(DEPTH));
	assign do_pop  = pop_i & ~empty_o;
	assign do_push = push_i & (~full_o | do_pop);   // a pop frees the slot.
	assign data_o  = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= data_i;
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_o <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count_o <= count_o + 1'b1;
			else if (do_pop && !do_push)
				count_o <= count_o - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* source/uart_regs.sv */
`timescale 1ns/1ns
`default_nettype none
`include "uart_defines.svh"

module uart_regs
	import uart_pkg::*;
(
	input  wire                    clk,
	input  wire                    wb_rst_i,
	input  wire [`UART_ADDR_W-1:0] addr_i,
	input  wire [7:0]              wdata_i,
	input  wire                    we_i,
	input  wire                    re_i,
	output logic [7:0]             rdata_o,
	output lcr_t                   lcr_o,
	output logic [15:0]            divisor_o,
	output logic                   div_load_o,
	output logic                   tx_push_o,
	output logic [7:0]             tx_data_o,
	output logic                   rx_pop_o,
	input  wire                    tx_empty_i,
	input  wire                    tx_idle_i,
	input  wire                    rx_ready_i,
	input  wire rx_entry_t         rx_head_i,
	input  wire                    rx_overrun_i
);
	logic       data_sel;
	logic       dlm_sel;
	logic       lsr_read;
	logic       overrun_nxt;
	logic [7:0] lsr;

	assign data_sel  = (addr_i == `UART_REG_DATA);
	assign dlm_sel   = (addr_i == `UART_REG_DLM);
	assign lsr_read  = re_i && (addr_i == `UART_REG_LSR);

	assign tx_push_o = we_i & data_sel & ~lcr_o.dlab;
	assign tx_data_o = wdata_i;
	assign rx_pop_o  = re_i & data_sel & ~lcr_o.dlab;

	// a new overrun wins over the clearing read.
	assign overrun_nxt = rx_overrun_i | (lsr[1] & ~lsr_read);

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			lcr_o      <= lcr_t'(8'h03);    // 8 bits, no parity.
			divisor_o  <= '0;
			div_load_o <= 1'b0;
		end
		else
		begin
			// baud counter restarts once the new byte is in place.
			div_load_o <= we_i & lcr_o.dlab & (data_sel | dlm_sel);
			if (we_i && addr_i == `UART_REG_LCR)
				lcr_o <= lcr_t'(wdata_i);
			if (we_i && lcr_o.dlab && data_sel)
				divisor_o[7:0] <= wdata_i;
			if (we_i && lcr_o.dlab && dlm_sel)
				divisor_o[15:8] <= wdata_i;
		end
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
			lsr <= 8'h60;
		else
			lsr <= {1'b0, tx_empty_i & tx_idle_i, tx_empty_i, 1'b0,
				rx_ready_i & rx_head_i.frm_err, rx_ready_i & rx_head_i.par_err,
				overrun_nxt, rx_ready_i};
	end

	always_comb
	begin
		case (addr_i)
			`UART_REG_DATA: rdata_o = lcr_o.dlab ? divisor_o[7:0] : rx_head_i.data;
			`UART_REG_DLM:  rdata_o = lcr_o.dlab ? divisor_o[15:8] : 8'h00;
			`UART_REG_LCR:  rdata_o = lcr_o;
			`UART_REG_LSR:  rdata_o = lsr;
			default:        rdata_o = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

/* source/uart_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "uart_defines.svh"

module uart_top
	import uart_pkg::*;
(
	input  wire                    clk,
	input  wire                    wb_rst_i,
	input  wire [`UART_ADDR_W-1:0] addr_i,
	input  wire [7:0]              wdata_i,
	input  wire                    we_i,
	input  wire                    re_i,
	output logic [7:0]             rdata_o,
	output logic                   stx_pad_o,
	input  wire                    srx_pad_i
);
	lcr_t        lcr;
	logic [15:0] divisor;
	logic        div_load;
	logic        tick;
	logic        tx_push;
	logic [7:0]  tx_data;
	logic        rx_pop;
	logic        tx_empty;
	logic        tx_idle;
	logic        rx_ready;
	rx_entry_t   rx_head;
	logic        rx_overrun;

	uart_regs i_regs (
		.clk          (clk),
		.wb_rst_i     (wb_rst_i),
		.addr_i       (addr_i),
		.wdata_i      (wdata_i),
		.we_i         (we_i),
		.re_i         (re_i),
		.rdata_o      (rdata_o),
		.lcr_o        (lcr),
		.divisor_o    (divisor),
		.div_load_o   (div_load),
		.tx_push_o    (tx_push),
		.tx_data_o    (tx_data),
		.rx_pop_o     (rx_pop),
		.tx_empty_i   (tx_empty),
		.tx_idle_i    (tx_idle),
		.rx_ready_i   (rx_ready),
		.rx_head_i    (rx_head),
		.rx_overrun_i (rx_overrun)
	);

	uart_baud_gen i_baud_gen (
		.clk        (clk),
		.wb_rst_i   (wb_rst_i),
		.divisor_i  (divisor),
		.div_load_i (div_load),
		.tick_o     (tick)
	);

	uart_tx i_tx (
		.clk        (clk),
		.wb_rst_i   (wb_rst_i),
		.tick_i     (tick),
		.lcr_i      (lcr),
		.push_i     (tx_push),
		.data_i     (tx_data),
		.stx_pad_o  (stx_pad_o),
		.tx_empty_o (tx_empty),
		.tx_idle_o  (tx_idle)
	);

	uart_rx i_rx (
		.clk          (clk),
		.wb_rst_i     (wb_rst_i),
		.tick_i       (tick),
		.lcr_i        (lcr),
		.srx_pad_i    (srx_pad_i),
		.pop_i        (rx_pop),
		.rx_head_o    (rx_head),
		.rx_ready_o   (rx_ready),
		.rx_overrun_o (rx_overrun)
	);

endmodule

`default_nettype wire

/* transmitter/uart_tx.sv */
`timescale 1ns/1ns
`default_nettype none
`include "uart_defines.svh"

module uart_tx
	import uart_pkg::*;
(
	input  wire       clk,
	input  wire       wb_rst_i,
	input  wire       tick_i,
	input  wire lcr_t lcr_i,
	input  wire       push_i,
	input  wire [7:0] data_i,
	output logic      stx_pad_o,
	output logic      tx_empty_o,
	output logic      tx_idle_o
);
	localparam int TW = $clog2(`UART_OVERSAMPLE);
	localparam logic [TW-1:0] TICK_LAST = TW'(`UART_OVERSAMPLE - 1);

	typedef enum logic [2:0] {S_IDLE, S_START, S_DATA, S_PARITY, S_STOP} tx_state_t;

	tx_state_t     state;
	logic [TW-1:0] tick_cnt;
	logic [2:0]    bit_cnt;
	logic [7:0]    shift;
	logic          par_bit;
	logic          stop_more;
	logic          pop;
	logic [7:0]    head;
	logic [7:0]    word_mask;

	uart_fifo #(.WIDTH(8)) i_tx_fifo (
		.clk      (clk),
		.wb_rst_i (wb_rst_i),
		.push_i   (push_i),
		.pop_i    (pop),
		.data_i   (data_i),
		.data_o   (head),
		.count_o  (),
		.full_o   (),
		.empty_o  (tx_empty_o)
	);

	assign word_mask = 8'hff >> (2'd3 - lcr_i.wlen);
	assign pop       = tick_i && state == S_IDLE && !tx_empty_o;
	assign tx_idle_o = (state == S_IDLE);

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			state     <= S_IDLE;
			tick_cnt  <= '0;
			bit_cnt   <= '0;
			shift     <= '0;
			par_bit   <= 1'b0;
			stop_more <= 1'b0;
			stx_pad_o <= 1'b1;
		end
		else if (pop)
		begin
			shift     <= head;
			par_bit   <= ^(head & word_mask) ^ ~lcr_i.even_par;
			tick_cnt  <= '0;
			stx_pad_o <= 1'b0;                 // start bit.
			state     <= S_START;
		end
		else if (tick_i && state != S_IDLE)
		begin
			tick_cnt <= (tick_cnt == TICK_LAST) ? '0 : tick_cnt + 1'b1;
			if (tick_cnt == TICK_LAST)
			begin
				case (state)
					S_START:
					begin
						state     <= S_DATA;
						bit_cnt   <= '0;
						stx_pad_o <= shift[0];
						shift     <= shift >> 1;
					end
					S_DATA:
					begin
						// last bit index is the word length minus one.
						if (bit_cnt == {1'b1, lcr_i.wlen})
						begin
							if (lcr_i.par_en)
							begin
								state     <= S_PARITY;
								stx_pad_o <= par_bit;
							end
							else
							begin
								state     <= S_STOP;
								stx_pad_o <= 1'b1;
								stop_more <= lcr_i.stop2;
							end
						end
						else
						begin
							bit_cnt   <= bit_cnt + 1'b1;
							stx_pad_o <= shift[0];
							shift     <= shift >> 1;
						end
					end
					S_PARITY:
					begin
						state     <= S_STOP;
						stx_pad_o <= 1'b1;
						stop_more <= lcr_i.stop2;
					end
					S_STOP:
					begin
						if (stop_more)
							stop_more <= 1'b0;
						else
							state <= S_IDLE;
					end
					default: state <= S_IDLE;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* verification/uart_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "uart_defines.svh"

module uart_tb
	import uart_pkg::*;
();
	logic                    clk;
	logic                    wb_rst_i;
	logic [`UART_ADDR_W-1:0] addr;
	logic [7:0]              wdata;
	logic                    we;
	logic                    re;
	logic [7:0]              rdata;
	logic                    stx;
	logic                    srx;
	logic                    model_line;
	logic                    use_model;
	logic                    timed_out;
	int                      errors;
	int                      checks;

	// receive line comes from the serial model or straight from the transmitter.
	assign srx = use_model ? model_line : stx;

	uart_top i_dut (
		.clk       (clk),
		.wb_rst_i  (wb_rst_i),
		.addr_i    (addr),
		.wdata_i   (wdata),
		.we_i      (we),
		.re_i      (re),
		.rdata_o   (rdata),
		.stx_pad_o (stx),
		.srx_pad_i (srx)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_value(input string name, input int exp, input int act);
		checks++;
		assert (exp == act)
		else
		begin
			$display("Error: %s expected 0x%0h actual 0x%0h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_near(input string name, input int exp, input int act, input int tol);
		checks++;
		assert (act >= exp - tol && act <= exp + tol)
		else
		begin
			$display("Error: %s expected %0d actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		timed_out = 1'b1;
		@(posedge clk);
	endtask

	task automatic bus_write(input logic [`UART_ADDR_W-1:0] a, input logic [7:0] d);
		@(posedge clk);
		addr  <= a;
		wdata <= d;
		we    <= 1'b1;
		@(posedge clk);
		we <= 1'b0;
	endtask

	// read data is sampled mid cycle before the strobe acts at the next edge.
	task automatic bus_read(input logic [`UART_ADDR_W-1:0] a, output logic [7:0] d);
		@(posedge clk);
		addr <= a;
		re   <= 1'b1;
		@(negedge clk);
		d = rdata;
		@(posedge clk);
		re <= 1'b0;
	endtask

	task automatic wait_status(input logic [7:0] mask, input string what, output logic [7:0] lsr);
		int polls;
		polls = 0;
		bus_read(`UART_REG_LSR, lsr);
		while ((lsr & mask) != mask && polls < 5000)
		begin
			bus_read(`UART_REG_LSR, lsr);
			polls++;
		end
		if ((lsr & mask) != mask)
			report_timeout(what);
	endtask

	// counts clocks until the transmit line shows the given level.
	task automatic wait_line(input logic level, output int cycles);
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
		end
		while (stx !== level && cycles < 4000);
		if (stx !== level)
			report_timeout("a transmit line edge");
	endtask

	function automatic logic [7:0] word_mask(input lcr_t lc);
		logic [8:0] m;
		m = (9'd1 << (lc.wlen + 5)) - 9'd1;
		return m[7:0];
	endfunction

	function automatic int frame_bits(input lcr_t lc);
		return 2 + lc.wlen + 5 + lc.par_en + lc.stop2;
	endfunction

	function automatic lcr_t random_lcr();
		logic [7:0] r;
		r = 8'($urandom());
		r[7:5] = 3'b000;          // dlab and reserved bits clear.
		return lcr_t'(r);
	endfunction

	task automatic drive_bit(input logic b);
		@(posedge clk);
		model_line <= b;
		repeat (31) @(posedge clk);    // one bit is 16 ticks of 2 clocks.
	endtask

	task automatic send_frame(input logic [7:0] d, input lcr_t lc, input logic bad_par,
		input logic bad_stop);
		logic par;
		par = ^(d & word_mask(lc)) ^ ~lc.even_par ^ bad_par;
		drive_bit(1'b0);
		for (int i = 0; i < lc.wlen + 5; i++)
			drive_bit(d[i]);
		if (lc.par_en)
			drive_bit(par);
		drive_bit(~bad_stop);
		if (lc.stop2)
			drive_bit(1'b1);
		drive_bit(1'b1);                 // idle gap.
	endtask

	initial
	begin
		wait (timed_out);
		$display("Checks: %0d, errors: %0d, timeouts: 1", checks, errors);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		logic [7:0] v;
		logic [7:0] d1;
		logic [7:0] rd;
		logic [7:0] lsr;
		logic [7:0] q [$];
		lcr_t       lc;
		int         n;
		int         t_low;
		int         t_gap;

		void'($urandom(32'h941));
		wb_rst_i   = 1'b1;
		addr       = '0;
		wdata      = '0;
		we         = 1'b0;
		re         = 1'b0;
		model_line = 1'b1;
		use_model  = 1'b0;
		timed_out  = 1'b0;
		errors     = 0;
		checks     = 0;
		repeat (3) @(posedge clk);
		wb_rst_i <= 1'b0;

		// reset_values
		bus_read(`UART_REG_LCR, rd);
		check_value("reset_values lcr", 8'h03, rd);
		bus_read(`UART_REG_LSR, rd);
		check_value("reset_values lsr", 8'h60, rd);
		check_value("reset_values stx", 1, stx);

		// register_readback
		repeat (4)
		begin
			v  = 8'($urandom()) | 8'h80;
			d1 = 8'($urandom());
			n  = $urandom_range(255, 0);
			bus_write(`UART_REG_LCR, v);
			bus_write(`UART_REG_DATA, 8'(n));
			bus_write(`UART_REG_DLM, d1);
			bus_read(`UART_REG_LCR, rd);
			check_value("register_readback lcr", v, rd);
			bus_read(`UART_REG_DATA, rd);
			check_value("register_readback dll", n, rd);
			bus_read(`UART_REG_DLM, rd);
			check_value("register_readback dlm", d1, rd);
			bus_write(`UART_REG_LCR, v & 8'h7f);
			bus_read(`UART_REG_DLM, rd);
			check_value("register_readback dlm hidden", 0, rd);
		end
		bus_write(`UART_REG_LCR, 8'h83);
		bus_write(`UART_REG_DATA, 8'd2);
		bus_write(`UART_REG_DLM, 8'd0);
		bus_write(`UART_REG_LCR, 8'h03);

		// loopback_data
		repeat (6)
		begin
			lc = random_lcr();
			bus_write(`UART_REG_LCR, lc);
			n = $urandom_range(16, 1);
			q = {};
			for (int i = 0; i < n; i++)
			begin
				v = 8'($urandom());
				q.push_back(v & word_mask(lc));
				bus_write(`UART_REG_DATA, v);
			end
			for (int i = 0; i < n; i++)
			begin
				wait_status(8'h01, "received data", lsr);
				check_value("loopback_data lsr errors", 0, lsr & 8'h0e);
				bus_read(`UART_REG_DATA, rd);
				check_value("loopback_data", q.pop_front(), rd);
			end
			wait_status(8'h40, "transmitter empty", lsr);
		end

		// bit_timing sends an all ones first frame so its start bit is its only low.
		repeat (3)
		begin
			lc = random_lcr();
			lc.even_par = ~lc.wlen[0];
			bus_write(`UART_REG_LCR, lc);
			v = 8'($urandom());
			bus_write(`UART_REG_DATA, 8'hff);
			bus_write(`UART_REG_DATA, v);
			wait_line(1'b0, t_low);
			wait_line(1'b1, t_low);
			wait_line(1'b0, t_gap);
			check_near("bit_timing start bit", 32, t_low, 1);
			check_value("bit_timing frame bits", frame_bits(lc), (t_low + t_gap) / 32);
			wait_status(8'h01, "received data", lsr);
			bus_read(`UART_REG_DATA, rd);
			check_value("bit_timing first byte", word_mask(lc), rd);
			wait_status(8'h01, "received data", lsr);
			bus_read(`UART_REG_DATA, rd);
			check_value("bit_timing second byte", v & word_mask(lc), rd);
			wait_status(8'h40, "transmitter empty", lsr);
		end

		// error_flags with 8 bits and even parity.
		lc = lcr_t'(8'h1b);
		bus_write(`UART_REG_LCR, lc);
		use_model <= 1'b1;
		v  = 8'($urandom());
		d1 = 8'($urandom());
		send_frame(v, lc, 1'b1, 1'b0);
		send_frame(d1, lc, 1'b0, 1'b1);
		wait_status(8'h01, "received data", lsr);
		check_value("error_flags parity", 8'h04, lsr & 8'h0c);
		bus_read(`UART_REG_DATA, rd);
		check_value("error_flags parity data", v, rd);
		wait_status(8'h01, "received data", lsr);
		check_value("error_flags framing", 8'h08, lsr & 8'h0c);
		bus_read(`UART_REG_DATA, rd);
		check_value("error_flags framing data", d1, rd);

		// overrun drops the seventeenth frame.
		lc = lcr_t'(8'h03);
		bus_write(`UART_REG_LCR, lc);
		q = {};
		for (int i = 0; i < 17; i++)
		begin
			v = 8'($urandom());
			if (i < 16)
				q.push_back(v);
			send_frame(v, lc, 1'b0, 1'b0);
		end
		bus_read(`UART_REG_LSR, lsr);
		check_value("overrun flag set", 1, lsr[1]);
		bus_read(`UART_REG_LSR, lsr);
		check_value("overrun flag clear", 0, lsr[1]);
		for (int i = 0; i < 16; i++)
		begin
			bus_read(`UART_REG_LSR, lsr);
			check_value("overrun data ready", 1, lsr[0]);
			bus_read(`UART_REG_DATA, rd);
			check_value("overrun data", q.pop_front(), rd);
		end
		bus_read(`UART_REG_LSR, lsr);
		check_value("overrun entry count", 0, lsr[0]);

		$display("Checks: %0d, errors: %0d, timeouts: 0", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
